// File: Makefile
VERILATOR   ?= verilator
TOP         ?= tb_issue
FLIST       ?= flist.f
OBJ_DIR     ?= obj_dir
LOG         ?= sim.log
ERROR_LIMIT ?= 100
VFLAGS      ?= --binary --timing --assert -j 0
PASS_MSG    ?= TEST PASS

SOURCES := $(shell cat $(FLIST))

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+$(ERROR_LIMIT) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: flist.f
hw/issue_pkg.sv
hw/instr_queue.sv
hw/operand_read_stage.sv
hw/hazard_stall.sv
hw/execute_stage.sv
hw/writeback_regfile.sv
hw/issue_top.sv
testbench/issue_props.sv
testbench/tb_issue.sv

// File: hw/execute_stage.sv
module execute_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              issue_valid,
    input  issue_pkg::issue_t issue_data,
    output logic              wb_valid,
    output issue_pkg::wb_t    wb_data
);
    import issue_pkg::*;

    logic [xlen-1:0]           dmem [mem_words];
    logic                      is_mem;
    logic [xlen-1:0]           addr_sum;
    logic [xlen-1:0]           alu_result;
    logic                      alu_valid;
    wb_t                       alu_q;
    logic                      mem_valid;
    op_t                       mem_op;
    logic [reg_addr_width-1:0] mem_rd;
    logic [mem_addr_width-1:0] mem_addr;
    logic [xlen-1:0]           mem_wdata;
    logic                      st_valid;
    logic                      ld_valid;
    wb_t                       ld_q;

    assign is_mem   = (issue_data.op == OP_LOAD) || (issue_data.op == OP_STORE);
    assign addr_sum = issue_data.a + issue_data.imm;

    always_comb begin
        case (issue_data.op)
            OP_ADD:  alu_result = issue_data.a + issue_data.b;
            OP_SUB:  alu_result = issue_data.a - issue_data.b;
            OP_AND:  alu_result = issue_data.a & issue_data.b;
            OP_OR:   alu_result = issue_data.a | issue_data.b;
            OP_XOR:  alu_result = issue_data.a ^ issue_data.b;
            OP_ADDI: alu_result = addr_sum;
            default: alu_result = '0;
        endcase
    end

    // alu path, one register stage.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alu_valid <= 1'b0;
            mem_valid <= 1'b0;
            ld_valid  <= 1'b0;
        end else begin
            alu_valid <= issue_valid && !is_mem;
            mem_valid <= issue_valid && is_mem;
            ld_valid  <= mem_valid && (mem_op == OP_LOAD);
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid && !is_mem) begin
            alu_q.op    <= issue_data.op;
            alu_q.rd    <= issue_data.rd;
            alu_q.value <= alu_result;
            alu_q.wen   <= 1'b1;
        end
        // memory path, first stage holds the address.
        if (issue_valid && is_mem) begin
            mem_op    <= issue_data.op;
            mem_rd    <= issue_data.rd;
            mem_addr  <= addr_sum[mem_addr_width-1:0];
            mem_wdata <= issue_data.b;
        end
        // second stage registers the read word.
        if (mem_valid && (mem_op == OP_LOAD)) begin
            ld_q.op    <= mem_op;
            ld_q.rd    <= mem_rd;
            ld_q.value <= dmem[mem_addr];
            ld_q.wen   <= 1'b1;
        end
    end

    // a store retires from the first memory stage and writes at its end.
    assign st_valid = mem_valid && (mem_op == OP_STORE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < mem_words; i++) begin
                dmem[i] <= '0;
            end
        end else if (st_valid) begin
            dmem[mem_addr] <= mem_wdata;
        end
    end

    // at most one of the three sources is valid in any cycle.
    assign wb_valid = alu_valid || st_valid || ld_valid;

    always_comb begin
        if (ld_valid) begin
            wb_data = ld_q;
        end else if (st_valid) begin
            wb_data.op    = mem_op;
            wb_data.rd    = mem_rd;
            wb_data.value = mem_wdata;
            wb_data.wen   = 1'b0;
        end else begin
            wb_data = alu_q;
        end
    end

endmodule

// File: hw/hazard_stall.sv
module hazard_stall (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   dec_valid,
    input  issue_pkg::instr_t                      dec_instr,
    input  logic                                   issue_valid,
    input  logic                                   wb_valid,
    input  logic [issue_pkg::reg_addr_width-1:0]   wb_rd,
    input  logic [issue_pkg::retire_cnt_width-1:0] retire_free,
    output logic                                   issue_ok
);
    import issue_pkg::*;

    logic [num_regs-1:0]         busy;
    logic                        load_last;
    logic [retire_cnt_width-1:0] inflight;
    logic                        use_rs2;
    logic                        rs1_wait;
    logic                        rs2_wait;
    logic                        writes_rd;

    // addi and load have no second source.
    assign use_rs2   = !(dec_instr.op == OP_ADDI || dec_instr.op == OP_LOAD);
    assign rs1_wait  = (dec_instr.rs1 != '0) && busy[dec_instr.rs1];
    assign rs2_wait  = use_rs2 && (dec_instr.rs2 != '0) && busy[dec_instr.rs2];
    assign writes_rd = (dec_instr.op != OP_STORE) && (dec_instr.rd != '0);

    // a load lands two cycles out, so an alu op right behind it would
    // hit writeback in the same cycle.
    assign issue_ok = dec_valid && !rs1_wait && !rs2_wait && !load_last
                      && (retire_free > inflight);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= '0;
            load_last <= 1'b0;
            inflight  <= '0;
        end else begin
            if (wb_valid) begin
                busy[wb_rd] <= 1'b0;
            end
            // set after clear so a new writer of the same register wins.
            if (issue_valid && writes_rd) begin
                busy[dec_instr.rd] <= 1'b1;
            end
            load_last <= issue_valid && (dec_instr.op == OP_LOAD);
            case ({issue_valid, wb_valid})
                2'b10:   inflight <= inflight + 1'b1;
                2'b01:   inflight <= inflight - 1'b1;
                default: inflight <= inflight;
            endcase
        end
    end

endmodule

// File: hw/instr_queue.sv
module instr_queue (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    output logic              in_ready,
    input  issue_pkg::instr_t in_instr,
    output logic              q_valid,
    input  logic              q_ready,
    output issue_pkg::instr_t q_instr
);
    import issue_pkg::*;

    instr_t     entry [2];
    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;
    logic       push;
    logic       pop;

    // ready comes from the occupancy register only, never from decode.
    assign in_ready = (count != 2'd2);
    assign q_valid  = (count != 2'd0);
    assign q_instr  = entry[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = q_valid && q_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
            case ({push, pop})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entry[wr_ptr] <= in_instr;
        end
    end

endmodule

// File: hw/issue_pkg.sv
package issue_pkg;

    // datapath and register file sizes.
    localparam int xlen = 32;
    localparam int reg_addr_width = 5;
    localparam int num_regs = 32;
    localparam int imm_width = 12;

    // data memory and retire queue sizes.
    localparam int mem_words = 16;
    localparam int mem_addr_width = 4;
    localparam int retire_depth = 4;
    localparam int retire_cnt_width = $clog2(retire_depth + 1);

    typedef enum logic [2:0] {
        OP_ADD   = 3'd0,
        OP_SUB   = 3'd1,
        OP_AND   = 3'd2,
        OP_OR    = 3'd3,
        OP_XOR   = 3'd4,
        OP_ADDI  = 3'd5,
        OP_LOAD  = 3'd6,
        OP_STORE = 3'd7
    } op_t;

    // pre-decoded instruction as it arrives on the input port.
    typedef struct packed {
        op_t                       op;
        logic [reg_addr_width-1:0] rd;
        logic [reg_addr_width-1:0] rs1;
        logic [reg_addr_width-1:0] rs2;
        logic [imm_width-1:0]      imm;
    } instr_t;

    // decode to execute, operands already read.
    typedef struct packed {
        op_t                       op;
        logic [reg_addr_width-1:0] rd;
        logic [xlen-1:0]           a;
        logic [xlen-1:0]           b;
        logic [xlen-1:0]           imm;
    } issue_t;

    typedef struct packed {
        op_t                       op;
        logic [reg_addr_width-1:0] rd;
        logic [xlen-1:0]           value;
        logic                      wen;
    } wb_t;

    typedef struct packed {
        op_t                       op;
        logic [reg_addr_width-1:0] rd;
        logic [xlen-1:0]           value;
        logic                      wen;
    } retire_t;

endpackage

// File: hw/issue_top.sv
module issue_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    output logic               in_ready,
    input  issue_pkg::instr_t  in_instr,
    output logic               out_valid,
    input  logic               out_ready,
    output issue_pkg::retire_t out_retire
);
    import issue_pkg::*;

    logic                        q_valid;
    logic                        q_ready;
    instr_t                      q_instr;
    logic                        dec_valid;
    instr_t                      dec_instr;
    logic                        issue_ok;
    logic [reg_addr_width-1:0]   rs1;
    logic [reg_addr_width-1:0]   rs2;
    logic [xlen-1:0]             rs1_data;
    logic [xlen-1:0]             rs2_data;
    logic                        issue_valid;
    issue_t                      issue_data;
    logic                        wb_valid;
    wb_t                         wb_data;
    logic [retire_cnt_width-1:0] retire_free;

    instr_queue instr_queue_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_instr (in_instr),
        .q_valid  (q_valid),
        .q_ready  (q_ready),
        .q_instr  (q_instr)
    );

    operand_read_stage operand_read_stage_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .q_valid     (q_valid),
        .q_ready     (q_ready),
        .q_instr     (q_instr),
        .dec_valid   (dec_valid),
        .dec_instr   (dec_instr),
        .issue_ok    (issue_ok),
        .rs1         (rs1),
        .rs2         (rs2),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .issue_valid (issue_valid),
        .issue_data  (issue_data)
    );

    hazard_stall hazard_stall_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .dec_valid   (dec_valid),
        .dec_instr   (dec_instr),
        .issue_valid (issue_valid),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_data.rd),
        .retire_free (retire_free),
        .issue_ok    (issue_ok)
    );

    execute_stage execute_stage_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue_data  (issue_data),
        .wb_valid    (wb_valid),
        .wb_data     (wb_data)
    );

    writeback_regfile writeback_regfile_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .wb_valid    (wb_valid),
        .wb_data     (wb_data),
        .rs1         (rs1),
        .rs2         (rs2),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .retire_free (retire_free),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_retire  (out_retire)
    );

endmodule

// File: hw/operand_read_stage.sv
module operand_read_stage (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                q_valid,
    output logic                                q_ready,
    input  issue_pkg::instr_t                   q_instr,
    output logic                                dec_valid,
    output issue_pkg::instr_t                   dec_instr,
    input  logic                                issue_ok,
    output logic [issue_pkg::reg_addr_width-1:0] rs1,
    output logic [issue_pkg::reg_addr_width-1:0] rs2,
    input  logic [issue_pkg::xlen-1:0]          rs1_data,
    input  logic [issue_pkg::xlen-1:0]          rs2_data,
    output logic                                issue_valid,
    output issue_pkg::issue_t                   issue_data
);
    import issue_pkg::*;

    logic fire;

    // the decode slot empties on the same edge that it issues.
    assign fire        = dec_valid && issue_ok;
    assign issue_valid = fire;
    assign q_ready     = !dec_valid || fire;

    // source addresses go straight to the register file.
    assign rs1 = dec_instr.rs1;
    assign rs2 = dec_instr.rs2;

    always_comb begin
        issue_data.op  = dec_instr.op;
        issue_data.rd  = dec_instr.rd;
        issue_data.a   = rs1_data;
        issue_data.b   = rs2_data;
        // sign-extend the immediate to full width.
        issue_data.imm = {{(xlen - imm_width){dec_instr.imm[imm_width-1]}}, dec_instr.imm};
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else if (q_ready) begin
            dec_valid <= q_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (q_valid && q_ready) begin
            dec_instr <= q_instr;
        end
    end

endmodule

// File: hw/writeback_regfile.sv
module writeback_regfile (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   wb_valid,
    input  issue_pkg::wb_t                         wb_data,
    input  logic [issue_pkg::reg_addr_width-1:0]   rs1,
    input  logic [issue_pkg::reg_addr_width-1:0]   rs2,
    output logic [issue_pkg::xlen-1:0]             rs1_data,
    output logic [issue_pkg::xlen-1:0]             rs2_data,
    output logic [issue_pkg::retire_cnt_width-1:0] retire_free,
    output logic                                   out_valid,
    input  logic                                   out_ready,
    output issue_pkg::retire_t                     out_retire
);
    import issue_pkg::*;

    logic [xlen-1:0]                 regs [num_regs];
    logic                            reg_we;
    retire_t                         fifo [retire_depth];
    logic [$clog2(retire_depth)-1:0] wr_ptr;
    logic [$clog2(retire_depth)-1:0] rd_ptr;
    logic [retire_cnt_width-1:0]     count;
    logic                            pop;

    // r0 is never written.
    assign reg_we = wb_valid && wb_data.wen && (wb_data.rd != '0);

    function automatic logic [xlen-1:0] read_reg(input logic [reg_addr_width-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        // same-cycle write passes through.
        if (reg_we && (wb_data.rd == addr)) begin
            return wb_data.value;
        end
        return regs[addr];
    endfunction

    assign rs1_data = read_reg(rs1);
    assign rs2_data = read_reg(rs2);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_we) begin
            regs[wb_data.rd] <= wb_data.value;
        end
    end

    // retire fifo, never full on push thanks to the issue credit check.
    assign out_valid   = (count != '0);
    assign out_retire  = fifo[rd_ptr];
    assign pop         = out_valid && out_ready;
    assign retire_free = retire_cnt_width'(retire_depth) - count;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wb_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wb_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wb_valid) begin
            fifo[wr_ptr].op    <= wb_data.op;
            fifo[wr_ptr].rd    <= wb_data.rd;
            fifo[wr_ptr].value <= wb_data.value;
            fifo[wr_ptr].wen   <= wb_data.wen;
        end
    end

endmodule

// File: testbench/issue_props.sv
module issue_props (
    input logic               clk,
    input logic               rst_n,
    input logic               in_valid,
    input logic               in_ready,
    input logic               out_valid,
    input logic               out_ready,
    input issue_pkg::retire_t out_retire,
    input issue_pkg::instr_t  dec_instr,
    input logic               issue_valid,
    input logic               wb_valid,
    input issue_pkg::wb_t     wb_data
);
    import issue_pkg::*;

    logic [num_regs-1:0] pending;
    logic                needs_rs2;
    logic                blocked;
    logic                held_bad = 1'b0;
    logic                hazard_bad = 1'b0;
    logic                load_bad = 1'b0;
    logic                reset_bad = 1'b0;
    logic                ready_bad = 1'b0;
    logic                violation;

    assign violation = held_bad | hazard_bad | load_bad | reset_bad | ready_bad;

    // own record of destinations still in flight.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= '0;
        end else begin
            if (wb_valid && wb_data.wen) begin
                pending[wb_data.rd] <= 1'b0;
            end
            if (issue_valid && (dec_instr.op != OP_STORE) && (dec_instr.rd != '0)) begin
                pending[dec_instr.rd] <= 1'b1;
            end
        end
    end

    assign needs_rs2 = !(dec_instr.op == OP_ADDI || dec_instr.op == OP_LOAD);
    assign blocked   = ((dec_instr.rs1 != '0) && pending[dec_instr.rs1])
                       || (needs_rs2 && (dec_instr.rs2 != '0) && pending[dec_instr.rs2]);

    retire_held: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_retire))
        else begin
            $error("retire output changed before out_ready");
            held_bad = 1'b1;
        end

    no_busy_issue: assert property (@(posedge clk) disable iff (!rst_n)
        issue_valid |-> !blocked)
        else begin
            $error("issue while a source register was still pending");
            hazard_bad = 1'b1;
        end

    no_issue_after_load: assert property (@(posedge clk) disable iff (!rst_n)
        issue_valid && (dec_instr.op == OP_LOAD) |=> !issue_valid)
        else begin
            $error("issue in the cycle right after a load issue");
            load_bad = 1'b1;
        end

    ready_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> in_ready)
        else begin
            $error("in_ready low after reset");
            reset_bad = 1'b1;
        end

    // the queue only fills through an accepted input.
    ready_falls_on_push: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(in_ready) |-> $past(in_valid))
        else begin
            $error("in_ready dropped without an input transfer");
            ready_bad = 1'b1;
        end

endmodule

bind issue_top issue_props issue_props_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_retire  (out_retire),
    .dec_instr   (dec_instr),
    .issue_valid (issue_valid),
    .wb_valid    (wb_valid),
    .wb_data     (wb_data)
);

// File: testbench/tb_issue.sv
module tb_issue;
    import issue_pkg::*;

    localparam int wd_cycles_per_instr = 200;

    logic    clk;
    logic    rst_n;
    logic    in_valid;
    logic    in_ready;
    instr_t  in_instr;
    logic    out_valid;
    logic    out_ready;
    retire_t out_retire;

    logic [xlen-1:0] ref_regs [num_regs];
    logic [xlen-1:0] ref_mem [mem_words];
    retire_t         exp_q [$];
    int              sent_count = 0;
    int              retired_count = 0;
    int              ready_mode = 0;
    string           test_name = "reset_state";

    issue_top issue_top_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_instr   (in_instr),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_retire (out_retire)
    );

    always #10 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    // architectural rules, applied in program order.
    function automatic retire_t model_step(input instr_t i);
        retire_t         r;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] imm_x;
        logic [xlen-1:0] addr;
        a = ref_regs[i.rs1];
        b = ref_regs[i.rs2];
        imm_x = xlen'($signed(i.imm));
        addr = a + imm_x;
        r.op = i.op;
        r.rd = i.rd;
        r.wen = 1'b1;
        case (i.op)
            OP_ADD:   r.value = a + b;
            OP_SUB:   r.value = a - b;
            OP_AND:   r.value = a & b;
            OP_OR:    r.value = a | b;
            OP_XOR:   r.value = a ^ b;
            OP_ADDI:  r.value = a + imm_x;
            OP_LOAD:  r.value = ref_mem[addr[mem_addr_width-1:0]];
            OP_STORE: begin
                ref_mem[addr[mem_addr_width-1:0]] = b;
                r.value = b;
                r.wen = 1'b0;
            end
        endcase
        if (r.wen && (i.rd != '0)) begin
            ref_regs[i.rd] = r.value;
        end
        return r;
    endfunction

    task automatic compare_field(input string field, input logic [31:0] exp,
                                 input logic [31:0] act);
        assert (exp === act) else begin
            abort_run($sformatf("[FAIL] %s retire %0d %s: expected %h, actual %h",
                                test_name, retired_count, field, exp, act));
        end
    endtask

    task automatic check_retire(input retire_t act);
        retire_t exp;
        assert (exp_q.size() != 0) else begin
            abort_run("a retire record came out with no instruction outstanding");
        end
        exp = exp_q.pop_front();
        compare_field("op", 32'(exp.op), 32'(act.op));
        compare_field("rd", 32'(exp.rd), 32'(act.rd));
        compare_field("value", exp.value, act.value);
        compare_field("wen", 32'(exp.wen), 32'(act.wen));
        retired_count++;
    endtask

    // called at a falling edge, returns at a falling edge.
    task automatic send_instr(input instr_t i);
        in_valid = 1'b1;
        in_instr = i;
        while (!in_ready) begin
            @(negedge clk);
        end
        exp_q.push_back(model_step(i));
        sent_count++;
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic emit(input op_t op, input int rd, input int rs1, input int rs2,
                        input int imm);
        instr_t i;
        i.op = op;
        i.rd = 5'(rd);
        i.rs1 = 5'(rs1);
        i.rs2 = 5'(rs2);
        i.imm = 12'(imm);
        send_instr(i);
    endtask

    task automatic wait_drain();
        while (retired_count != sent_count) begin
            @(negedge clk);
        end
    endtask

    // mode changes land on the rising edge, away from the sampling edge.
    task automatic set_ready_mode(input int mode);
        @(posedge clk);
        ready_mode = mode;
        @(negedge clk);
    endtask

    task automatic send_random(input int len, input int bubble_pct);
        for (int n = 0; n < len; n++) begin
            if (int'($urandom_range(0, 99)) < bubble_pct) begin
                @(negedge clk);
            end
            emit(op_t'(3'($urandom_range(0, 7))), $urandom_range(0, 5),
                 $urandom_range(0, 5), $urandom_range(0, 5), $urandom_range(0, 4095));
        end
    endtask

    task automatic check_reset_state();
        assert (in_ready) else abort_run("in_ready is low after reset");
        repeat (3) begin
            assert (!out_valid) else abort_run("out_valid rose with nothing sent");
            @(negedge clk);
        end
    endtask

    task automatic run_independent();
        test_name = "independent_alu";
        for (int r = 1; r <= 8; r++) begin
            emit(OP_ADDI, r, 0, 0, $urandom_range(0, 4095));
        end
        for (int k = 0; k < 8; k++) begin
            emit(op_t'(3'($urandom_range(0, 4))), 9 + k, $urandom_range(1, 8),
                 $urandom_range(1, 8), 0);
        end
        emit(OP_ADDI, 17, 3, 0, -5);
        wait_drain();
    endtask

    task automatic run_chains();
        test_name = "dependent_chain";
        emit(OP_ADDI, 1, 0, 0, 7);
        emit(OP_ADDI, 1, 1, 0, 5);
        emit(OP_ADD, 2, 1, 1, 0);
        emit(OP_SUB, 3, 2, 1, 0);
        emit(OP_XOR, 3, 3, 2, 0);
        emit(OP_OR, 4, 3, 3, 0);
        emit(OP_AND, 4, 4, 2, 0);
        // x0 write is dropped, the next read must see zero.
        emit(OP_ADDI, 0, 4, 0, 99);
        emit(OP_ADD, 5, 0, 4, 0);
        emit(OP_ADDI, 6, 0, 0, -1);
        emit(OP_SUB, 6, 0, 6, 0);
        wait_drain();
    endtask

    task automatic run_load_store();
        test_name = "load_store";
        emit(OP_ADDI, 7, 0, 0, 'h123);
        emit(OP_ADDI, 8, 0, 0, -300);
        emit(OP_STORE, 0, 0, 7, 3);
        emit(OP_STORE, 0, 0, 8, 5);
        emit(OP_LOAD, 9, 0, 0, 3);
        emit(OP_ADD, 10, 9, 9, 0);
        emit(OP_LOAD, 11, 0, 0, 5);
        emit(OP_XOR, 12, 7, 8, 0);
        emit(OP_STORE, 0, 7, 12, -'h120);
        emit(OP_LOAD, 13, 0, 0, 3);
        emit(OP_LOAD, 14, 0, 0, -1);
        // offset 30 wraps onto word 14.
        emit(OP_STORE, 0, 0, 11, 30);
        emit(OP_LOAD, 15, 0, 0, 14);
        emit(OP_ADD, 16, 15, 13, 0);
        wait_drain();
    endtask

    task automatic run_backpressure();
        int waited;
        test_name = "backpressure";
        set_ready_mode(2);
        fork
            send_random(24, 0);
            begin
                waited = 0;
                while (in_ready && (waited < 60)) begin
                    @(negedge clk);
                    waited++;
                end
                assert (!in_ready) else begin
                    abort_run("in_ready never dropped while out_ready was held low");
                end
                repeat (8) @(negedge clk);
                set_ready_mode(1);
            end
        join
        wait_drain();
    endtask

    // pick out_ready on the output side, then check any transfer on the next edge.
    always @(negedge clk) begin
        if (rst_n) begin
            case (ready_mode)
                0:       out_ready = 1'b1;
                1:       out_ready = (int'($urandom_range(0, 9)) < 6);
                default: out_ready = 1'b0;
            endcase
            if (out_valid && out_ready) begin
                check_retire(out_retire);
            end
        end
    end

    // the watchdog budget grows with every instruction sent.
    initial begin
        int cycles;
        cycles = 0;
        forever begin
            @(negedge clk);
            cycles++;
            if (issue_top_inst.issue_props_inst.violation) begin
                abort_run("a bound DUT assertion failed, see the error above");
            end else if (cycles > wd_cycles_per_instr * (sent_count + 8)) begin
                abort_run("watchdog expired before the DUT retired all instructions");
            end
        end
    end

    initial begin
        void'($urandom(32'h1a335f8d));
        clk = 1'b0;
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_instr = '0;
        out_ready = 1'b1;
        for (int r = 0; r < num_regs; r++) begin
            ref_regs[r] = '0;
        end
        for (int w = 0; w < mem_words; w++) begin
            ref_mem[w] = '0;
        end
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        check_reset_state();
        run_independent();
        run_chains();
        run_load_store();
        test_name = "random_mixed";
        send_random(40, 20);
        wait_drain();
        set_ready_mode(1);
        send_random(40, 10);
        send_random(60, 30);
        wait_drain();
        run_backpressure();
        repeat (4) @(negedge clk);
        if (issue_top_inst.issue_props_inst.violation) begin
            abort_run("a bound DUT assertion failed during the run");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule
